//--- source/ipd_defs.svh
/*
 * Inter-packet delay shared definitions
 * Queue count, stream and register widths, register map indices
 */

`ifndef IPD_DEFS_SVH
`define IPD_DEFS_SVH

// Queue count and stream widths
`define IPD_NUM_QUEUES 4
`define IPD_DATA_W     64
`define IPD_TUSER_W    64

// Lowest bit of the per-packet delay field in tuser
`define IPD_TS_POS     32

// Register word and address widths
`define IPD_REG_W      32
`define IPD_REG_ADDR_W 4

// Register index within a queue, address = queue * 4 + index
`define IPD_REG_SW_RST  2'd0
`define IPD_REG_EN      2'd1
`define IPD_REG_USE_REG 2'd2
`define IPD_REG_DELAY   2'd3

`endif

//--- source/ipd_pkg.sv
/*
 * Inter-packet delay types
 * Register word seen either as a single control flag or as a cycle count
 */

`include "ipd_defs.svh"

package ipd_pkg;

  // Control view, only the flag bit is stored
  typedef struct packed {
    logic [`IPD_REG_W-2:0] rsvd;
    logic                  flag;
  } reg_ctrl_t;

  // One register word, decoded by register index
  typedef union packed {
    reg_ctrl_t             ctrl;
    logic [`IPD_REG_W-1:0] cycles;
  } reg_word_u;

endpackage

//--- source/ipd_reg_bank.sv
/*
 * Inter-packet delay register bank
 * Per-queue soft reset, enable, delay source and delay value registers
 * with a single-cycle write strobe and combinational readback
 */

`include "ipd_defs.svh"

module ipd_reg_bank (
  input  logic                       axis_aclk,
  input  logic                       rst_n,

  input  logic                       reg_wr_en,
  input  logic [`IPD_REG_ADDR_W-1:0] reg_wr_addr,
  input  ipd_pkg::reg_word_u         reg_wr_data,
  input  logic [`IPD_REG_ADDR_W-1:0] reg_rd_addr,
  output ipd_pkg::reg_word_u         reg_rd_data,

  output logic                       sw_rst        [`IPD_NUM_QUEUES],
  output logic                       ipd_en        [`IPD_NUM_QUEUES],
  output logic                       use_reg_val   [`IPD_NUM_QUEUES],
  output logic [`IPD_REG_W-1:0]      delay_reg_val [`IPD_NUM_QUEUES]
);

  import ipd_pkg::*;

  // Upper address bits select the queue, lowest two the register
  localparam int QW = `IPD_REG_ADDR_W - 2;

  logic [QW-1:0] wr_q;
  logic [1:0]    wr_idx;
  logic [QW-1:0] rd_q;
  logic [1:0]    rd_idx;
  reg_word_u     rd_word;

  assign wr_q   = reg_wr_addr[`IPD_REG_ADDR_W-1:2];
  assign wr_idx = reg_wr_addr[1:0];
  assign rd_q   = reg_rd_addr[`IPD_REG_ADDR_W-1:2];
  assign rd_idx = reg_rd_addr[1:0];

  // Register write
  always_ff @(posedge axis_aclk) begin
    if (!rst_n) begin
      for (int q = 0; q < `IPD_NUM_QUEUES; q++) begin
        sw_rst[q]        <= 1'b0;
        ipd_en[q]        <= 1'b0;
        use_reg_val[q]   <= 1'b0;
        delay_reg_val[q] <= '0;
      end
    end else if (reg_wr_en) begin
      case (wr_idx)
        `IPD_REG_SW_RST:  sw_rst[wr_q]        <= reg_wr_data.ctrl.flag;
        `IPD_REG_EN:      ipd_en[wr_q]        <= reg_wr_data.ctrl.flag;
        `IPD_REG_USE_REG: use_reg_val[wr_q]   <= reg_wr_data.ctrl.flag;
        default:          delay_reg_val[wr_q] <= reg_wr_data.cycles;
      endcase
    end
  end

  // Readback, reserved control bits return zero
  always_comb begin
    rd_word = '0;
    case (rd_idx)
      `IPD_REG_SW_RST:  rd_word.ctrl.flag = sw_rst[rd_q];
      `IPD_REG_EN:      rd_word.ctrl.flag = ipd_en[rd_q];
      `IPD_REG_USE_REG: rd_word.ctrl.flag = use_reg_val[rd_q];
      default:          rd_word.cycles    = delay_reg_val[rd_q];
    endcase
  end

  assign reg_rd_data = rd_word;

endmodule

//--- source/inter_packet_delay.sv
/*
 * Inter-packet delay engine for one stream
 * Holds the first beat of each packet until the programmed gap has passed
 */

`include "ipd_defs.svh"

module inter_packet_delay #(
  parameter int DATA_W  = `IPD_DATA_W,
  parameter int TUSER_W = `IPD_TUSER_W
) (
  input  logic                  axis_aclk,
  input  logic                  rst_n,

  // Input stream
  input  logic [DATA_W-1:0]     s_axis_tdata,
  input  logic [TUSER_W-1:0]    s_axis_tuser,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,

  // Output stream
  output logic [DATA_W-1:0]     m_axis_tdata,
  output logic [TUSER_W-1:0]    m_axis_tuser,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,

  // Control from the register bank
  input  logic                  sw_rst,
  input  logic                  ipd_en,
  input  logic                  use_reg_val,
  input  logic [`IPD_REG_W-1:0] delay_reg_val
);

  // Next beat on the stream opens a packet
  logic                  first_beat;
  // Last beat has gone out, gap not yet loaded
  logic                  pending;
  // Remaining closed cycles after the load cycle
  logic [`IPD_REG_W-1:0] gap_cnt;

  logic [`IPD_REG_W-1:0] gap_sel;
  logic                  gap_load;
  logic                  gate_closed;
  logic                  xfer;

  // Delay source, register or timestamp field of the waiting beat
  assign gap_sel = use_reg_val ? delay_reg_val
                               : s_axis_tuser[`IPD_TS_POS +: `IPD_REG_W];

  // Gap is loaded once the next first beat is presented
  assign gap_load = pending && s_axis_tvalid && first_beat;

  // Only first beats are held, the load cycle itself counts as closed
  always_comb begin
    gate_closed = 1'b0;
    if (ipd_en && !sw_rst && first_beat) begin
      if (gap_cnt != '0) begin
        gate_closed = 1'b1;
      end else if (pending && gap_sel != '0) begin
        gate_closed = 1'b1;
      end
    end
  end

  // Payload passes straight through
  assign m_axis_tdata  = s_axis_tdata;
  assign m_axis_tuser  = s_axis_tuser;
  assign m_axis_tlast  = s_axis_tlast;

  // Handshake gate
  assign m_axis_tvalid = s_axis_tvalid && !gate_closed;
  assign s_axis_tready = m_axis_tready && !gate_closed;

  assign xfer = m_axis_tvalid && m_axis_tready;

  // Packet boundary tracking
  always_ff @(posedge axis_aclk) begin
    if (!rst_n || sw_rst) begin
      first_beat <= 1'b1;
    end else if (xfer) begin
      first_beat <= s_axis_tlast;
    end
  end

  // Pending flag and gap counter
  always_ff @(posedge axis_aclk) begin
    if (!rst_n || sw_rst) begin
      pending <= 1'b0;
      gap_cnt <= '0;
    end else begin
      if (gap_load && gap_cnt == '0) begin
        pending <= 1'b0;
        // Load cycle is the first closed cycle
        gap_cnt <= (gap_sel == '0) ? '0 : gap_sel - 1'b1;
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end

      // A packet end arms the next gap, overriding a same-cycle load
      if (xfer && s_axis_tlast && ipd_en) begin
        pending <= 1'b1;
      end
    end
  end

endmodule

//--- source/ipd_top.sv
/*
 * Four-queue inter-packet delay top level
 * One register bank feeding a delay engine per queue
 */

`include "ipd_defs.svh"

module ipd_top (
  input  logic                       axis_aclk,
  input  logic                       rst_n,

  // Register port
  input  logic                       reg_wr_en,
  input  logic [`IPD_REG_ADDR_W-1:0] reg_wr_addr,
  input  ipd_pkg::reg_word_u         reg_wr_data,
  input  logic [`IPD_REG_ADDR_W-1:0] reg_rd_addr,
  output ipd_pkg::reg_word_u         reg_rd_data,

  // Input streams
  input  logic [`IPD_DATA_W-1:0]     s_axis_tdata  [`IPD_NUM_QUEUES],
  input  logic [`IPD_TUSER_W-1:0]    s_axis_tuser  [`IPD_NUM_QUEUES],
  input  logic                       s_axis_tvalid [`IPD_NUM_QUEUES],
  output logic                       s_axis_tready [`IPD_NUM_QUEUES],
  input  logic                       s_axis_tlast  [`IPD_NUM_QUEUES],

  // Output streams
  output logic [`IPD_DATA_W-1:0]     m_axis_tdata  [`IPD_NUM_QUEUES],
  output logic [`IPD_TUSER_W-1:0]    m_axis_tuser  [`IPD_NUM_QUEUES],
  output logic                       m_axis_tvalid [`IPD_NUM_QUEUES],
  input  logic                       m_axis_tready [`IPD_NUM_QUEUES],
  output logic                       m_axis_tlast  [`IPD_NUM_QUEUES]
);

  // Per-queue control
  logic                  sw_rst        [`IPD_NUM_QUEUES];
  logic                  ipd_en        [`IPD_NUM_QUEUES];
  logic                  use_reg_val   [`IPD_NUM_QUEUES];
  logic [`IPD_REG_W-1:0] delay_reg_val [`IPD_NUM_QUEUES];

  ipd_reg_bank reg_bank_i (
    .axis_aclk     (axis_aclk),
    .rst_n         (rst_n),
    .reg_wr_en     (reg_wr_en),
    .reg_wr_addr   (reg_wr_addr),
    .reg_wr_data   (reg_wr_data),
    .reg_rd_addr   (reg_rd_addr),
    .reg_rd_data   (reg_rd_data),
    .sw_rst        (sw_rst),
    .ipd_en        (ipd_en),
    .use_reg_val   (use_reg_val),
    .delay_reg_val (delay_reg_val)
  );

  // One delay engine per queue
  for (genvar q = 0; q < `IPD_NUM_QUEUES; q++) begin : g_queue
    inter_packet_delay #(
      .DATA_W  (`IPD_DATA_W),
      .TUSER_W (`IPD_TUSER_W)
    ) ipd_i (
      .axis_aclk     (axis_aclk),
      .rst_n         (rst_n),
      .s_axis_tdata  (s_axis_tdata[q]),
      .s_axis_tuser  (s_axis_tuser[q]),
      .s_axis_tvalid (s_axis_tvalid[q]),
      .s_axis_tready (s_axis_tready[q]),
      .s_axis_tlast  (s_axis_tlast[q]),
      .m_axis_tdata  (m_axis_tdata[q]),
      .m_axis_tuser  (m_axis_tuser[q]),
      .m_axis_tvalid (m_axis_tvalid[q]),
      .m_axis_tready (m_axis_tready[q]),
      .m_axis_tlast  (m_axis_tlast[q]),
      .sw_rst        (sw_rst[q]),
      .ipd_en        (ipd_en[q]),
      .use_reg_val   (use_reg_val[q]),
      .delay_reg_val (delay_reg_val[q])
    );
  end

endmodule

//--- tb/ipd_props.sv
/*
 * Inter-packet delay stream properties
 * Bound into each delay engine to check the gate against its input
 */

module ipd_props #(
  parameter int DATA_W = 64
) (
  input logic              axis_aclk,
  input logic              rst_n,
  input logic              s_axis_tvalid,
  input logic              m_axis_tvalid,
  input logic [DATA_W-1:0] s_axis_tdata,
  input logic [DATA_W-1:0] m_axis_tdata,
  input logic              ipd_en,
  input logic              sw_rst
);

  timeunit 1ns;
  timeprecision 1ps;

  // The gate never invents a beat
  a_valid_from_input: assert property (@(posedge axis_aclk) disable iff (!rst_n)
    m_axis_tvalid |-> s_axis_tvalid)
    else $error("output valid without input valid");

  a_data_through: assert property (@(posedge axis_aclk) disable iff (!rst_n)
    m_axis_tdata == s_axis_tdata)
    else $error("output data differs from input data");

  // Disabled engine is a plain wire
  a_passthrough: assert property (@(posedge axis_aclk) disable iff (!rst_n)
    (!ipd_en && !sw_rst) |-> (m_axis_tvalid == s_axis_tvalid))
    else $error("disabled engine changed valid");

endmodule

bind inter_packet_delay ipd_props #(.DATA_W(DATA_W)) props_i (
  .axis_aclk     (axis_aclk),
  .rst_n         (rst_n),
  .s_axis_tvalid (s_axis_tvalid),
  .m_axis_tvalid (m_axis_tvalid),
  .s_axis_tdata  (s_axis_tdata),
  .m_axis_tdata  (m_axis_tdata),
  .ipd_en        (ipd_en),
  .sw_rst        (sw_rst)
);

//--- tb/tb_ipd.sv
/*
 * Inter-packet delay testbench
 * Drives packets on all queues and checks data order and packet gaps
 */

`include "ipd_defs.svh"

module tb_ipd;

  timeunit 1ns;
  timeprecision 1ps;

  import ipd_pkg::*;

  localparam int NQ        = `IPD_NUM_QUEUES;
  localparam int PERIOD    = 40;
  localparam int NUM_TESTS = 6;
  localparam int NUM_PKTS  = 6;

  typedef struct packed {
    logic                    last;
    logic [`IPD_TUSER_W-1:0] user;
    logic [`IPD_DATA_W-1:0]  data;
  } beat_t;

  logic                       axis_aclk = 1'b0;
  logic                       rst_n;
  logic                       reg_wr_en;
  logic [`IPD_REG_ADDR_W-1:0] reg_wr_addr;
  reg_word_u                  reg_wr_data;
  logic [`IPD_REG_ADDR_W-1:0] reg_rd_addr;
  reg_word_u                  reg_rd_data;
  logic [`IPD_DATA_W-1:0]     s_axis_tdata  [NQ];
  logic [`IPD_TUSER_W-1:0]    s_axis_tuser  [NQ];
  logic                       s_axis_tvalid [NQ];
  logic                       s_axis_tready [NQ];
  logic                       s_axis_tlast  [NQ];
  logic [`IPD_DATA_W-1:0]     m_axis_tdata  [NQ];
  logic [`IPD_TUSER_W-1:0]    m_axis_tuser  [NQ];
  logic                       m_axis_tvalid [NQ];
  logic                       m_axis_tready [NQ];
  logic                       m_axis_tlast  [NQ];

  integer seed = 32'h876f_a524;
  int     errors = 0;
  int     cyc = 0;
  bit     bp_on = 0;
  beat_t  src_q [NQ][$];
  beat_t  exp_q [NQ][$];
  beat_t  out_q [NQ][$];
  int     out_cyc [NQ][$];
  bit     took [NQ];
  bit     started [NQ];
  int     start_cyc [NQ];
  bit     cfg_en [NQ];
  bit     cfg_use [NQ];
  int     cfg_dly [NQ];

  ipd_top dut_i (.*);

  always #(PERIOD / 2) axis_aclk = ~axis_aclk;

  // Expected idle cycles before a packet whose first beat carries tuser
  function automatic int expected_gap(bit en, bit use_reg, int dly,
                                      logic [`IPD_TUSER_W-1:0] tuser);
    if (!en) begin
      return 0;
    end
    return use_reg ? dly : int'(tuser[`IPD_TS_POS +: `IPD_REG_W]);
  endfunction

  function automatic int rand_below(int n);
    return {$random(seed)} % n;
  endfunction

  task automatic check_val(logic [191:0] got, logic [191:0] want, string msg);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, msg, got, want);
      errors++;
    end
  endtask

  // Transfers seen at each rising edge
  always @(posedge axis_aclk) begin
    for (int q = 0; q < NQ; q++) begin
      took[q] = s_axis_tvalid[q] && s_axis_tready[q];
      if (m_axis_tvalid[q] && m_axis_tready[q]) begin
        out_q[q].push_back({m_axis_tlast[q], m_axis_tuser[q], m_axis_tdata[q]});
        out_cyc[q].push_back(cyc);
      end
    end
    cyc++;
  end

  // Sources and sinks change on the falling edge
  always @(negedge axis_aclk) begin
    for (int q = 0; q < NQ; q++) begin
      if (took[q] && src_q[q].size() > 0) begin
        void'(src_q[q].pop_front());
      end
      took[q] = 1'b0;
      s_axis_tvalid[q] = src_q[q].size() > 0;
      if (src_q[q].size() > 0) begin
        {s_axis_tlast[q], s_axis_tuser[q], s_axis_tdata[q]} = src_q[q][0];
        if (!started[q]) begin
          started[q]   = 1'b1;
          start_cyc[q] = cyc;
        end
      end
      m_axis_tready[q] = bp_on ? rand_below(2) == 0 : 1'b1;
    end
  end

  task automatic reg_write(int addr, logic [31:0] value);
    @(negedge axis_aclk);
    reg_wr_en          = 1'b1;
    reg_wr_addr        = addr[`IPD_REG_ADDR_W-1:0];
    reg_wr_data.cycles = value;
    @(negedge axis_aclk);
    reg_wr_en = 1'b0;
  endtask

  task automatic reg_check(int addr, logic [31:0] want);
    @(negedge axis_aclk);
    reg_rd_addr = addr[`IPD_REG_ADDR_W-1:0];
    @(posedge axis_aclk);
    check_val(reg_rd_data.cycles, want, $sformatf("register %0d", addr));
  endtask

  // Program one queue, then clear its engine with a soft reset pulse
  task automatic configure(int q, bit en, bit use_reg, int dly);
    cfg_en[q]  = en;
    cfg_use[q] = use_reg;
    cfg_dly[q] = dly;
    reg_write(q * 4 + `IPD_REG_DELAY, dly);
    reg_write(q * 4 + `IPD_REG_USE_REG, use_reg);
    reg_write(q * 4 + `IPD_REG_EN, en);
    reg_write(q * 4 + `IPD_REG_SW_RST, 1);
    reg_write(q * 4 + `IPD_REG_SW_RST, 0);
  endtask

  task automatic queue_packets(int q, int npkts);
    int    len;
    beat_t b;
    for (int p = 0; p < npkts; p++) begin
      len = 1 + rand_below(4);
      for (int i = 0; i < len; i++) begin
        b.data = {$random(seed), $random(seed)};
        b.user = {32'(rand_below(21)), $random(seed)};
        b.last = (i == len - 1);
        src_q[q].push_back(b);
        exp_q[q].push_back(b);
      end
    end
  endtask

  task automatic clear_records();
    for (int q = 0; q < NQ; q++) begin
      exp_q[q].delete();
      out_q[q].delete();
      out_cyc[q].delete();
      started[q] = 1'b0;
    end
  endtask

  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge axis_aclk);
      busy = 1'b0;
      for (int q = 0; q < NQ; q++) begin
        if (out_q[q].size() < exp_q[q].size()) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // Gap mode 0 skips gaps, 1 wants exact gaps, 2 wants at least D
  task automatic compare_queue(int q, int mode);
    int gap;
    int d;
    check_val(out_q[q].size(), exp_q[q].size(), $sformatf("q%0d beat count", q));
    for (int i = 0; i < exp_q[q].size() && i < out_q[q].size(); i++) begin
      check_val(out_q[q][i], exp_q[q][i], $sformatf("q%0d beat %0d", q, i));
      if (i > 0 && exp_q[q][i-1].last && mode != 0) begin
        gap = out_cyc[q][i] - out_cyc[q][i-1] - 1;
        d   = expected_gap(cfg_en[q], cfg_use[q], cfg_dly[q], exp_q[q][i].user);
        if (mode == 1) begin
          check_val(gap, d, $sformatf("q%0d gap before beat %0d", q, i));
        end else begin
          check_val(gap >= d, 1, $sformatf("q%0d gap %0d below %0d", q, gap, d));
        end
      end
    end
    if (mode == 1 && out_cyc[q].size() > 0) begin
      check_val(out_cyc[q][0], start_cyc[q], $sformatf("q%0d first packet delayed", q));
    end
  endtask

  task automatic traffic_test(int mode);
    clear_records();
    for (int q = 0; q < NQ; q++) begin
      queue_packets(q, NUM_PKTS);
    end
    wait_drained();
    for (int q = 0; q < NQ; q++) begin
      compare_queue(q, mode);
    end
  endtask

  task automatic report(int num, string name, int errs_before);
    $display("test %0d %s: %s", num, name, errors == errs_before ? "ok" : "failed");
  endtask

  task automatic soft_reset_test();
    int n1;
    int rst_cyc;
    clear_records();
    configure(0, 1, 1, 1000);
    queue_packets(0, 2);
    n1 = 0;
    while (!exp_q[0][n1].last) begin
      n1++;
    end
    n1++;
    while (out_q[0].size() < n1) begin
      @(posedge axis_aclk);
    end
    repeat (5) @(negedge axis_aclk);
    rst_cyc = cyc;
    reg_write(`IPD_REG_SW_RST, 1);
    reg_write(`IPD_REG_SW_RST, 0);
    wait_drained();
    compare_queue(0, 0);
    check_val(out_cyc[0][n1] - rst_cyc <= 6, 1, "waiting packet held after soft reset");
  endtask

  // Watchdog
  initial begin
    #(2000 * NUM_TESTS * PERIOD);
    $display("timeout: the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int e;
    logic [31:0] wval [16];
    rst_n       = 1'b0;
    reg_wr_en   = 1'b0;
    reg_wr_addr = '0;
    reg_wr_data = '0;
    reg_rd_addr = '0;
    for (int q = 0; q < NQ; q++) begin
      s_axis_tdata[q]  = '0;
      s_axis_tuser[q]  = '0;
      s_axis_tvalid[q] = 1'b0;
      s_axis_tlast[q]  = 1'b0;
      m_axis_tready[q] = 1'b1;
      took[q]          = 1'b0;
      started[q]       = 1'b0;
    end
    repeat (16) @(posedge axis_aclk);
    @(negedge axis_aclk);
    rst_n = 1'b1;

    e = errors;
    for (int a = 0; a < 16; a++) begin
      reg_check(a, 0);
    end
    for (int a = 0; a < 16; a++) begin
      wval[a] = $random(seed);
      reg_write(a, wval[a]);
    end
    for (int a = 0; a < 16; a++) begin
      reg_check(a, (a % 4 == `IPD_REG_DELAY) ? wval[a] : {31'd0, wval[a][0]});
    end
    report(1, "register readback", e);

    e = errors;
    for (int q = 0; q < NQ; q++) begin
      configure(q, 0, 0, 0);
    end
    traffic_test(1);
    report(2, "passthrough", e);

    e = errors;
    for (int q = 0; q < NQ; q++) begin
      configure(q, 1, 1, rand_below(21));
    end
    traffic_test(1);
    report(3, "register delay", e);

    e = errors;
    for (int q = 0; q < NQ; q++) begin
      configure(q, 1, 0, 0);
    end
    traffic_test(1);
    report(4, "timestamp delay", e);

    e = errors;
    configure(0, 1, 1, rand_below(21));
    configure(1, 1, 0, 0);
    configure(2, 0, 1, 15);
    configure(3, 1, 1, rand_below(21));
    bp_on = 1'b1;
    traffic_test(2);
    bp_on = 1'b0;
    report(5, "back-pressure and independence", e);

    e = errors;
    soft_reset_test();
    report(6, "soft reset", e);

    $display("%0d tests run, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- ipd_top.f
+incdir+source
source/ipd_pkg.sv
source/ipd_reg_bank.sv
source/inter_packet_delay.sv
source/ipd_top.sv
tb/ipd_props.sv
tb/tb_ipd.sv

//--- Makefile
# Verilator build and run of the inter-packet delay testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f ipd_top.f \
		--top-module tb_ipd -Mdir $(OBJ_DIR) -o Vtb_ipd
	./$(OBJ_DIR)/Vtb_ipd 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
